//--- hw/core_isa_pkg.sv
package core_isa_pkg;

    localparam int reg_width = 16;
    localparam int reg_count = 8;
    localparam int imm_width = 8;

    typedef logic [2:0] reg_idx_t;

    typedef enum logic [3:0] {
        nop,
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        lshift,
        rshift,
        cmpge,
        setc,     // dst = imm
        setid,    // dst = core id
        ld,
        st,
        bnz,      // branch to imm if src_a != 0
        ready
    } opcode_t;

    typedef struct packed {
        opcode_t                opc;
        reg_idx_t               dst;
        reg_idx_t               src_a;
        reg_idx_t               src_b;
        logic [imm_width-1:0]   imm;
    } insn_t;

    localparam insn_t insn_nop = '{opc: nop, dst: '0, src_a: '0, src_b: '0, imm: '0};
    localparam insn_t insn_ready = '{opc: ready, dst: '0, src_a: '0, src_b: '0, imm: '0};

endpackage

//--- hw/core_mem_pkg.sv
package core_mem_pkg;

    localparam int data_width = 16;
    localparam int addr_width = 16;

    typedef logic [data_width-1:0] data_t;

    // request seen by the external data memory
    typedef struct packed {
        logic                   ld;
        logic                   st;
        logic [addr_width-1:0]  addr;
        data_t                  wdata;
    } mem_req_t;

endpackage

//--- hw/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl #(
    parameter int insn_depth = 32,
    localparam int ptr_width = $clog2(insn_depth) + 1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load_en,
    input  logic                 start,
    input  logic                 done,
    output logic                 ready,
    output logic                 run,
    output logic                 load_we,
    output logic                 fetch_clear,
    output logic [ptr_width-1:0] load_addr
);

    typedef enum logic {
        st_idle,
        st_run
    } state_t;

    state_t state;

    assign ready = state == st_idle;
    assign run = state == st_run;
    assign fetch_clear = ready && start;
    assign load_we = ready && load_en;   // program words only while idle

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_idle;
            load_addr <= '0;
        end
        else
        begin
            case (state)
                st_idle: if (start) state <= st_run;
                st_run: if (done) state <= st_idle;
                default: state <= st_idle;
            endcase
            if (fetch_clear)
                load_addr <= '0;
            else if (load_we)
                load_addr <= load_addr + 1'b1;
        end
    end

    a_load_in_range: assert property (@(posedge clk) disable iff (reset)
        load_we |-> load_addr < insn_depth)
        else $error("instruction word loaded past the last slot");

endmodule

//--- hw/insn_ptr.sv
`timescale 1ns/1ps

module insn_ptr
    import core_isa_pkg::*;
#(
    parameter int insn_depth = 32,
    localparam int ptr_width = $clog2(insn_depth) + 1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear,
    input  logic                 hold,
    input  logic                 branch_taken,
    input  logic [imm_width-1:0] branch_target,
    output logic [ptr_width-1:0] pc,
    output logic                 past_end
);

    logic [ptr_width-1:0] pc_q;   // address of the word now on the fetch output
    logic target_in_range;

    assign target_in_range = branch_target < insn_depth;
    assign past_end = pc_q >= insn_depth;

    // pc is the read address for the next cycle
    always_comb
    begin
        if (clear)
            pc = '0;
        else if (hold)
            pc = pc_q;
        else if (branch_taken)
            pc = target_in_range ? ptr_width'(branch_target) : ptr_width'(insn_depth);
        else if (past_end)
            pc = pc_q;   // park past the end
        else
            pc = pc_q + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            pc_q <= '0;
        else
            pc_q <= pc;
    end

endmodule

//--- hw/insn_memory.sv
`timescale 1ns/1ps

module insn_memory
    import core_isa_pkg::*;
#(
    parameter int insn_depth = 32,
    localparam int addr_bits = $clog2(insn_depth),
    localparam int ptr_width = addr_bits + 1
) (
    input  logic                 clk,
    input  logic                 we,
    input  logic [ptr_width-1:0] waddr,
    input  insn_t                wdata,
    input  logic [ptr_width-1:0] raddr,
    output insn_t                rdata
);

    insn_t mem [insn_depth];

    // top pointer bit only marks past the end, the store ignores it
    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr[addr_bits-1:0]] <= wdata;
    end

    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr[addr_bits-1:0]];   // registered read
    end

endmodule

//--- hw/register_file.sv
`timescale 1ns/1ps

module register_file
    import core_isa_pkg::*;
    import core_mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t ra,
    input  reg_idx_t rb,
    input  logic     we,
    input  reg_idx_t wa,
    input  data_t    wd,
    output data_t    da,
    output data_t    db
);

    data_t regs [reg_count];

    always_ff @(posedge clk)
    begin
        if (reset)
            regs <= '{default: '0};
        else if (we)
            regs[wa] <= wd;
    end

    // write-through, so decode sees what writeback stores this cycle
    assign da = (we && wa == ra) ? wd : regs[ra];
    assign db = (we && wa == rb) ? wd : regs[rb];

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps

module alu
    import core_isa_pkg::*;
    import core_mem_pkg::*;
(
    input  opcode_t opc,
    input  data_t   a,
    input  data_t   b,
    output data_t   result,
    output logic    nonzero
);

    always_comb
    begin
        case (opc)
            add:
                result = a + b;
            sub:
                result = a - b;
            and_op:
                result = a & b;
            or_op:
                result = a | b;
            xor_op:
                result = a ^ b;
            lshift:
                result = a << b[3:0];
            rshift:
                result = a >> b[3:0];   // logical
            cmpge:
                result = (a >= b) ? data_t'(1) : '0;
            default:
                result = '0;
        endcase
    end

    // bnz tests its first operand
    assign nonzero = |a;

endmodule

//--- hw/core_pipe.sv
`timescale 1ns/1ps

module core_pipe
    import core_isa_pkg::*;
    import core_mem_pkg::*;
#(
    parameter logic [reg_width-1:0] core_id = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  logic                 flush,
    input  insn_t                fetched,
    input  logic                 past_end,
    output logic                 hold,
    output logic                 branch_taken,
    output logic [imm_width-1:0] branch_target,
    output logic                 done,
    output mem_req_t             mem_req,
    input  data_t                mem_rdata,
    input  logic                 mem_ready
);

    insn_t d_insn;
    insn_t e_insn;
    insn_t m_insn;
    insn_t w_insn;
    insn_t fetch_insn;

    data_t e_a;
    data_t e_b;
    data_t m_result;   // alu result, constant or memory address
    data_t m_wdata;
    data_t w_result;
    data_t rf_da;
    data_t rf_db;
    data_t op_a;
    data_t op_b;
    data_t alu_result;
    data_t e_out;

    logic alu_nonzero;
    logic stall;
    logic mem_wait;
    logic freeze;

    function automatic logic is_arith(opcode_t opc);
        return opc inside {add, sub, and_op, or_op, xor_op, lshift, rshift, cmpge};
    endfunction

    function automatic logic writes_reg(opcode_t opc);
        return is_arith(opc) || opc inside {setc, setid, ld};
    endfunction

    function automatic logic reads_a(opcode_t opc);
        return is_arith(opc) || opc inside {ld, st, bnz};
    endfunction

    function automatic logic reads_b(opcode_t opc);
        return is_arith(opc) || opc == st;
    endfunction

    // newest producer wins
    function automatic data_t forward(reg_idx_t src, data_t val);
        if (writes_reg(m_insn.opc) && m_insn.dst == src)
            return m_result;
        if (writes_reg(w_insn.opc) && w_insn.dst == src)
            return w_result;
        return val;
    endfunction

    assign fetch_insn = past_end ? insn_ready : fetched;

    // a load in execute cannot feed the next instruction in time
    assign stall = e_insn.opc == ld
        && ((reads_a(d_insn.opc) && d_insn.src_a == e_insn.dst)
        || (reads_b(d_insn.opc) && d_insn.src_b == e_insn.dst));

    assign mem_wait = (m_insn.opc == ld || m_insn.opc == st) && !mem_ready;
    assign done = run && m_insn.opc == ready;
    assign freeze = !run || mem_wait || done;   // done keeps younger work out of memory
    assign hold = freeze || stall;

    register_file register_file_i (
        .clk   (clk),
        .reset (reset),
        .ra    (d_insn.src_a),
        .rb    (d_insn.src_b),
        .we    (writes_reg(w_insn.opc)),
        .wa    (w_insn.dst),
        .wd    (w_result),
        .da    (rf_da),
        .db    (rf_db)
    );

    always_comb
    begin
        op_a = forward(e_insn.src_a, e_a);
        op_b = forward(e_insn.src_b, e_b);
    end

    alu alu_i (
        .opc     (e_insn.opc),
        .a       (op_a),
        .b       (op_b),
        .result  (alu_result),
        .nonzero (alu_nonzero)
    );

    always_comb
    begin
        case (e_insn.opc)
            setc:
                e_out = reg_width'(e_insn.imm);
            setid:
                e_out = core_id;
            ld, st:
                e_out = op_a;
            default:
                e_out = alu_result;
        endcase
    end

    assign branch_taken = e_insn.opc == bnz && alu_nonzero;
    assign branch_target = e_insn.imm;

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            d_insn <= insn_nop;
            e_insn <= insn_nop;
            m_insn <= insn_nop;
            w_insn <= insn_nop;
        end
        else if (!freeze)
        begin
            w_insn <= m_insn;
            m_insn <= e_insn;
            e_insn <= (stall || branch_taken) ? insn_nop : d_insn;
            if (branch_taken)
                d_insn <= insn_nop;   // second younger slot
            else if (!stall)
                d_insn <= fetch_insn;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!freeze)
        begin
            e_a <= rf_da;
            e_b <= rf_db;
            m_result <= e_out;
            m_wdata <= op_b;
            w_result <= (m_insn.opc == ld) ? mem_rdata : m_result;
        end
    end

    always_comb
    begin
        mem_req.ld = m_insn.opc == ld;
        mem_req.st = m_insn.opc == st;
        mem_req.addr = m_result;
        mem_req.wdata = m_wdata;
    end

    a_load_use_stalled: assert property (@(posedge clk) disable iff (reset)
        m_insn.opc == ld |-> !(reads_a(e_insn.opc) && e_insn.src_a == m_insn.dst)
            && !(reads_b(e_insn.opc) && e_insn.src_b == m_insn.dst))
        else $error("load result used in execute before it returned");

    a_request_held: assert property (@(posedge clk) disable iff (reset)
        (mem_req.ld || mem_req.st) && !mem_ready |=> $stable(mem_req))
        else $error("memory request changed before mem_ready");

endmodule

//--- hw/core_top.sv
`timescale 1ns/1ps

module core_top
    import core_isa_pkg::*;
    import core_mem_pkg::*;
#(
    parameter logic [reg_width-1:0] core_id = '0,
    parameter int insn_depth = 32,
    localparam int ptr_width = $clog2(insn_depth) + 1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     load_en,
    input  insn_t    load_insn,
    input  logic     start,
    output logic     ready,
    output mem_req_t mem_req,
    input  data_t    mem_rdata,
    input  logic     mem_ready
);

    logic                 run;
    logic                 load_we;
    logic                 fetch_clear;
    logic                 done;
    logic                 hold;
    logic                 branch_taken;
    logic                 past_end;
    logic [imm_width-1:0] branch_target;
    logic [ptr_width-1:0] load_addr;
    logic [ptr_width-1:0] pc;
    insn_t                fetched;

    core_ctrl #(.insn_depth(insn_depth)) core_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .load_en     (load_en),
        .start       (start),
        .done        (done),
        .ready       (ready),
        .run         (run),
        .load_we     (load_we),
        .fetch_clear (fetch_clear),
        .load_addr   (load_addr)
    );

    insn_ptr #(.insn_depth(insn_depth)) insn_ptr_i (
        .clk           (clk),
        .reset         (reset),
        .clear         (fetch_clear),
        .hold          (hold),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc),
        .past_end      (past_end)
    );

    insn_memory #(.insn_depth(insn_depth)) insn_memory_i (
        .clk   (clk),
        .we    (load_we),
        .waddr (load_addr),
        .wdata (load_insn),
        .raddr (pc),
        .rdata (fetched)
    );

    core_pipe #(.core_id(core_id)) core_pipe_i (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .flush         (fetch_clear),
        .fetched       (fetched),
        .past_end      (past_end),
        .hold          (hold),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .done          (done),
        .mem_req       (mem_req),
        .mem_rdata     (mem_rdata),
        .mem_ready     (mem_ready)
    );

endmodule

//--- test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter realtime period = 4.0,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

    always #(period / 2) clk = ~clk;

endmodule

//--- test/core_tb.sv
`timescale 1ns/1ps

module core_tb
    import core_isa_pkg::*;
    import core_mem_pkg::*;
;

    localparam logic [15:0] tb_core_id = 16'h5a3c;
    localparam int insn_depth = 32;
    localparam int num_tests = 6;
    localparam int cycle_limit = 400 * num_tests;

    logic clk;
    logic reset;
    logic load_en;
    insn_t load_insn;
    logic start;
    logic ready;
    mem_req_t mem_req;
    data_t mem_rdata;
    logic mem_ready;

    integer seed = 32'h71da3970;
    int errors = 0;
    int failed_tests = 0;
    int cycles = 0;
    bit random_wait = 0;
    bit waiting = 0;
    int wait_left = 0;

    insn_t prog [insn_depth];
    data_t data_mem [64];
    data_t ref_mem [64];
    data_t ref_regs [reg_count];
    data_t exp_addr [$];
    data_t exp_data [$];

    clk_gen clk_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    core_top #(.core_id(tb_core_id), .insn_depth(insn_depth)) core_top_i (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_insn (load_insn),
        .start     (start),
        .ready     (ready),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    function automatic insn_t encode(opcode_t opc, reg_idx_t dst, reg_idx_t a, reg_idx_t b,
                                     logic [7:0] imm);
        insn_t i;
        i.opc = opc;
        i.dst = dst;
        i.src_a = a;
        i.src_b = b;
        i.imm = imm;
        return i;
    endfunction

    // runs prog on ref_regs and ref_mem, collects the stores in order
    function automatic void interpret();
        int pc;
        int steps;
        insn_t i;
        data_t a;
        data_t b;
        pc = 0;
        steps = 0;
        while (pc < insn_depth && steps < 2000)
        begin
            i = prog[pc];
            a = ref_regs[i.src_a];
            b = ref_regs[i.src_b];
            pc++;
            steps++;
            case (i.opc)
                add: ref_regs[i.dst] = a + b;
                sub: ref_regs[i.dst] = a - b;
                and_op: ref_regs[i.dst] = a & b;
                or_op: ref_regs[i.dst] = a | b;
                xor_op: ref_regs[i.dst] = a ^ b;
                lshift: ref_regs[i.dst] = a << b[3:0];
                rshift: ref_regs[i.dst] = a >> b[3:0];
                cmpge: ref_regs[i.dst] = (a >= b) ? 16'd1 : 16'd0;
                setc: ref_regs[i.dst] = {8'h00, i.imm};
                setid: ref_regs[i.dst] = tb_core_id;
                ld: ref_regs[i.dst] = ref_mem[a[5:0]];
                st:
                begin
                    ref_mem[a[5:0]] = b;
                    exp_addr.push_back(a);
                    exp_data.push_back(b);
                end
                bnz: if (a != 0) pc = i.imm;
                core_isa_pkg::ready: pc = insn_depth;
                default: ;
            endcase
        end
    endfunction

    // external data memory with optional wait states
    always @(posedge clk)
    begin
        if (reset)
        begin
            mem_ready <= 1'b0;
            waiting = 0;
        end
        else if (mem_ready)
        begin
            if (mem_req.st)
                data_mem[mem_req.addr[5:0]] = mem_req.wdata;
            mem_ready <= 1'b0;
            waiting = 0;
        end
        else if (mem_req.ld || mem_req.st)
        begin
            if (!waiting)
            begin
                waiting = 1;
                wait_left = random_wait ? int'($unsigned($random(seed)) % 4) : 0;
            end
            if (wait_left == 0)
            begin
                mem_ready <= 1'b1;
                mem_rdata <= data_mem[mem_req.addr[5:0]];
            end
            else
                wait_left--;
        end
    end

    always @(posedge clk)
    begin : compare_stores
        data_t ea;
        data_t ed;
        if (!reset && mem_req.st && mem_ready)
        begin
            assert (exp_addr.size() != 0)
            else
            begin
                errors++;
                $display("store to %h that the program should not make", mem_req.addr);
            end
            if (exp_addr.size() != 0)
            begin
                ea = exp_addr.pop_front();
                ed = exp_data.pop_front();
                assert (mem_req.addr == ea && mem_req.wdata == ed)
                else
                begin
                    errors++;
                    $display("** Error at %0t: store %h to %h, expected %h to %h",
                        $time, mem_req.wdata, mem_req.addr, ed, ea);
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= cycle_limit)
        begin
            $display("run stopped after %0d cycles, the core never finished", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic clear_prog();
        for (int i = 0; i < insn_depth; i++)
            prog[i] = insn_nop;
    endtask

    // load every slot, so no word of an earlier program survives
    task automatic run_program();
        ref_mem = data_mem;
        interpret();
        for (int i = 0; i < insn_depth; i++)
        begin
            @(posedge clk);
            load_en <= 1'b1;
            load_insn <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        while (!ready)
            @(posedge clk);
        @(posedge clk);
        assert (exp_addr.size() == 0)
        else
        begin
            errors++;
            $display("%0d expected stores never happened", exp_addr.size());
        end
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 64; i++)
        begin
            assert (data_mem[i] == ref_mem[i])
            else
            begin
                errors++;
                $display("** Error at %0t: memory word %0d is %h, expected %h",
                    $time, i, data_mem[i], ref_mem[i]);
            end
        end
    endtask

    task automatic report(input int num, input string name, input int errors_before);
        if (errors == errors_before)
            $display("test %0d %s: pass", num, name);
        else
        begin
            failed_tests++;
            $display("test %0d %s: fail, %0d errors", num, name, errors - errors_before);
        end
    endtask

    task automatic build_arith();
        opcode_t ops [8] = '{add, sub, and_op, or_op, xor_op, lshift, rshift, cmpge};
        clear_prog();
        prog[0] = encode(setc, 1, 0, 0, 8'h35);
        prog[1] = encode(setc, 2, 0, 0, 8'h0f);
        prog[2] = encode(setc, 6, 0, 0, 8'd1);
        prog[3] = encode(setc, 7, 0, 0, 8'd48);
        for (int i = 0; i < 8; i++)
        begin
            prog[4 + 3 * i] = encode(ops[i], 3, 1, 2, 0);
            prog[5 + 3 * i] = encode(st, 0, 7, 3, 0);
            prog[6 + 3 * i] = encode(add, 7, 7, 6, 0);
        end
        prog[28] = insn_ready;
    endtask

    task automatic build_hazards();
        clear_prog();
        prog[0] = encode(setc, 6, 0, 0, 8'd1);
        prog[1] = encode(setc, 1, 0, 0, 8'd7);
        prog[2] = encode(setc, 7, 0, 0, 8'd40);
        prog[3] = encode(add, 2, 1, 1, 0);     // r1 from writeback
        prog[4] = encode(add, 3, 2, 1, 0);     // r2 from memory stage
        prog[5] = encode(st, 0, 7, 3, 0);
        prog[6] = encode(ld, 4, 7, 0, 0);
        prog[7] = encode(add, 5, 4, 4, 0);     // load then use
        prog[8] = encode(add, 7, 7, 6, 0);
        prog[9] = encode(st, 0, 7, 5, 0);
        prog[10] = encode(ld, 4, 6, 0, 0);
        prog[11] = encode(xor_op, 5, 4, 1, 0);
        prog[12] = encode(sub, 5, 5, 4, 0);
        prog[13] = encode(add, 7, 7, 6, 0);
        prog[14] = encode(st, 0, 7, 5, 0);
        prog[15] = encode(ld, 2, 7, 0, 0);
        prog[16] = encode(st, 0, 6, 2, 0);     // load feeds store data
        prog[17] = insn_ready;
    endtask

    task automatic build_loop();
        clear_prog();
        prog[0] = encode(setc, 1, 0, 0, 8'd5);
        prog[1] = encode(setc, 6, 0, 0, 8'd1);
        prog[2] = encode(setc, 7, 0, 0, 8'd20);
        prog[3] = encode(st, 0, 7, 1, 0);
        prog[4] = encode(add, 7, 7, 6, 0);
        prog[5] = encode(sub, 1, 1, 6, 0);
        prog[6] = encode(bnz, 0, 1, 0, 8'd3);
        prog[7] = encode(st, 0, 6, 7, 0);     // flushed while looping
        prog[8] = insn_ready;
    endtask

    initial
    begin
        int errors_before;
        load_en = 1'b0;
        load_insn = insn_nop;
        start = 1'b0;
        mem_rdata = '0;
        mem_ready = 1'b0;
        for (int i = 0; i < reg_count; i++)
            ref_regs[i] = '0;
        for (int i = 0; i < 64; i++)
            data_mem[i] = data_t'($random(seed)) ^ data_t'(i * 16'h0101);
        @(posedge clk);
        while (reset)
            @(posedge clk);
        assert (ready && !mem_req.ld && !mem_req.st)
        else
        begin
            errors++;
            $display("core is not idle with no memory request after reset");
        end

        errors_before = errors;
        build_arith();
        run_program();
        report(1, "arithmetic and logic", errors_before);

        errors_before = errors;
        build_hazards();
        run_program();
        report(2, "bypass and load use", errors_before);

        errors_before = errors;
        build_loop();
        run_program();
        report(3, "branch loop", errors_before);

        errors_before = errors;
        random_wait = 1;
        build_hazards();
        run_program();
        build_loop();
        run_program();
        random_wait = 0;
        report(4, "memory wait states", errors_before);

        errors_before = errors;
        clear_prog();
        prog[0] = encode(setc, 1, 0, 0, 8'd9);
        prog[1] = encode(setc, 7, 0, 0, 8'd50);
        prog[2] = encode(st, 0, 7, 1, 0);
        run_program();
        clear_prog();
        prog[0] = encode(setc, 1, 0, 0, 8'h33);
        prog[1] = encode(setc, 7, 0, 0, 8'd51);
        prog[2] = encode(st, 0, 7, 1, 0);
        prog[3] = insn_ready;
        run_program();
        report(5, "run past end and reload", errors_before);

        errors_before = errors;
        clear_prog();
        prog[0] = encode(setid, 1, 0, 0, 0);
        prog[1] = encode(setc, 2, 0, 0, 8'ha5);
        prog[2] = encode(setc, 6, 0, 0, 8'd1);
        prog[3] = encode(setc, 7, 0, 0, 8'd60);
        prog[4] = encode(st, 0, 7, 1, 0);
        prog[5] = encode(add, 7, 7, 6, 0);
        prog[6] = encode(st, 0, 7, 2, 0);
        prog[7] = insn_ready;
        run_program();
        report(6, "core id and constant", errors_before);

        $display("tests %0d, failed %0d, errors %0d", num_tests, failed_tests, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- list.f
hw/core_isa_pkg.sv
hw/core_mem_pkg.sv
hw/core_ctrl.sv
hw/insn_ptr.sv
hw/insn_memory.sv
hw/register_file.sv
hw/alu.sv
hw/core_pipe.sv
hw/core_top.sv
test/clk_gen.sv
test/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP       ?= core_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then exit 1; fi
	@grep -q "Finished with no errors" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
